//--- logic/ooo_pkg.sv
package ooo_pkg;

    localparam int XLEN       = 32;
    localparam int NUM_REGS   = 32;
    localparam int REG_W      = 5;
    localparam int ROB_DEPTH  = 16;
    localparam int ROB_PTR_W  = $clog2(ROB_DEPTH);
    localparam int ROB_CNT_W  = ROB_PTR_W + 1;
    localparam int TAG_W      = 5;
    localparam int RS_DEPTH   = 4;
    localparam int RS_IDX_W   = $clog2(RS_DEPTH);
    localparam int MUL_STAGES = 3;

    // ROB entry plus one, zero means no pending producer
    typedef logic [TAG_W-1:0] tag_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
        ALU_SLL, ALU_SRL, ALU_ADDI, ALU_ANDI, ALU_ORI
    } alu_op_e;

    typedef enum logic {
        MUL_LO,
        MUL_HI
    } mul_op_e;

    // ALU codes come first and line up with alu_op_e
    typedef enum logic [3:0] {
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT,
        OP_SLL, OP_SRL, OP_ADDI, OP_ANDI, OP_ORI,
        OP_MUL, OP_MULH
    } op_e;

endpackage

//--- logic/issue_ctrl.sv
`timescale 1ns/1ps

module issue_ctrl
    import ooo_pkg::*;
(
    input  logic             issue_valid,
    input  op_e              issue_op,
    input  logic [REG_W-1:0] issue_rd,
    input  logic [REG_W-1:0] issue_rs,
    input  logic [REG_W-1:0] issue_rt,
    input  logic [15:0]      issue_imm,
    input  logic             rob_full,
    input  logic             alu_rs_full,
    input  logic             mul_rs_full,
    input  tag_t             alloc_tag,
    input  logic [XLEN-1:0]  rs_value,
    input  logic [XLEN-1:0]  rt_value,
    input  tag_t             rs_tag,
    input  tag_t             rt_tag,
    input  logic             lookup_ready_1,
    input  logic             lookup_ready_2,
    input  logic [XLEN-1:0]  lookup_data_1,
    input  logic [XLEN-1:0]  lookup_data_2,
    output logic             issue_ready,
    output logic             alloc,
    output logic             rename_en,
    output logic             alu_insert,
    output logic             mul_insert,
    output alu_op_e          alu_op,
    output mul_op_e          mul_op,
    output tag_t             src1_tag,
    output logic [XLEN-1:0]  src1_val,
    output tag_t             src2_tag,
    output logic [XLEN-1:0]  src2_val
);

    logic            is_mul;
    logic            is_imm;
    logic [XLEN-1:0] imm_ext;

    // Register value, ROB result or the tag to wait for
    function automatic logic [TAG_W+XLEN-1:0] operand(
        input logic            no_wait,
        input tag_t            t,
        input logic [XLEN-1:0] v,
        input logic            rdy,
        input logic [XLEN-1:0] fwd
    );
        if (no_wait || t == '0) return {{TAG_W{1'b0}}, v};
        if (rdy) return {{TAG_W{1'b0}}, fwd};
        return {t, {XLEN{1'b0}}};
    endfunction

    assign is_mul  = issue_op == OP_MUL || issue_op == OP_MULH;
    assign is_imm  = issue_op inside {OP_SLL, OP_SRL, OP_ADDI, OP_ANDI, OP_ORI};
    assign imm_ext = (issue_op == OP_ADDI) ? {{16{issue_imm[15]}}, issue_imm}
                                           : {16'd0, issue_imm};

    assign issue_ready = !(rob_full || (is_mul ? mul_rs_full : alu_rs_full));
    assign alloc       = issue_valid && issue_ready;
    assign rename_en   = alloc && issue_rd != '0;
    assign alu_insert  = alloc && !is_mul;
    assign mul_insert  = alloc && is_mul;
    assign alu_op      = alu_op_e'(issue_op);
    assign mul_op      = (issue_op == OP_MULH) ? MUL_HI : MUL_LO;

    assign {src1_tag, src1_val} = operand(issue_rs == '0, rs_tag, rs_value,
                                          lookup_ready_1, lookup_data_1);
    assign {src2_tag, src2_val} = is_imm ? {{TAG_W{1'b0}}, imm_ext}
                                         : operand(issue_rt == '0, rt_tag, rt_value,
                                                   lookup_ready_2, lookup_data_2);

endmodule

//--- logic/rename_regfile.sv
`timescale 1ns/1ps

module rename_regfile
    import ooo_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic [REG_W-1:0] rd_rs,
    input  logic [REG_W-1:0] rd_rt,
    input  logic             rename_en,
    input  logic [REG_W-1:0] rename_rd,
    input  tag_t             rename_tag,
    input  logic             commit_en,
    input  logic [REG_W-1:0] commit_rd,
    input  tag_t             commit_tag,
    input  logic [XLEN-1:0]  commit_data,
    output logic [XLEN-1:0]  rs_value,
    output tag_t             rs_tag,
    output logic [XLEN-1:0]  rt_value,
    output tag_t             rt_tag
);

    logic [XLEN-1:0] regs [NUM_REGS];
    tag_t            tags [NUM_REGS];

    assign rs_value = regs[rd_rs];
    assign rs_tag   = tags[rd_rs];
    assign rt_value = regs[rd_rt];
    assign rt_tag   = tags[rd_rt];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
                tags[i] <= '0;
            end
        end else begin
            if (commit_en && commit_rd != '0) begin
                regs[commit_rd] <= commit_data;
                // Only the youngest producer releases the register
                if (tags[commit_rd] == commit_tag) begin
                    tags[commit_rd] <= '0;
                end
            end
            if (rename_en) begin
                tags[rename_rd] <= rename_tag;
            end
        end
    end

    a_r0_never_renamed: assert property (@(posedge clk) disable iff (rst)
        tags[0] == '0);

endmodule

//--- logic/reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer
    import ooo_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             alloc,
    input  logic [REG_W-1:0] alloc_rd,
    input  tag_t             lookup_tag_1,
    input  tag_t             lookup_tag_2,
    input  logic             cdb_a_valid,
    input  tag_t             cdb_a_tag,
    input  logic [XLEN-1:0]  cdb_a_data,
    input  logic             cdb_b_valid,
    input  tag_t             cdb_b_tag,
    input  logic [XLEN-1:0]  cdb_b_data,
    output tag_t             alloc_tag,
    output logic             rob_full,
    output logic             lookup_ready_1,
    output logic [XLEN-1:0]  lookup_data_1,
    output logic             lookup_ready_2,
    output logic [XLEN-1:0]  lookup_data_2,
    output logic             commit_valid,
    output logic [REG_W-1:0] commit_rd,
    output tag_t             commit_tag,
    output logic [XLEN-1:0]  commit_data
);

    logic [ROB_PTR_W-1:0] head;
    logic [ROB_PTR_W-1:0] tail;
    logic [ROB_CNT_W-1:0] count;
    logic [ROB_DEPTH-1:0] ready;
    logic [ROB_DEPTH-1:0] live;
    logic [REG_W-1:0]     rd_q  [ROB_DEPTH];
    logic [XLEN-1:0]      value [ROB_DEPTH];
    logic [ROB_PTR_W-1:0] idx_a;
    logic [ROB_PTR_W-1:0] idx_b;
    logic [ROB_PTR_W-1:0] idx_1;
    logic [ROB_PTR_W-1:0] idx_2;
    logic                 head_done;

    assign idx_a = ROB_PTR_W'(cdb_a_tag - 1'b1);
    assign idx_b = ROB_PTR_W'(cdb_b_tag - 1'b1);
    assign idx_1 = ROB_PTR_W'(lookup_tag_1 - 1'b1);
    assign idx_2 = ROB_PTR_W'(lookup_tag_2 - 1'b1);

    assign alloc_tag = tag_t'(tail) + 1'b1;
    assign rob_full  = count == ROB_CNT_W'(ROB_DEPTH);
    assign head_done = live[head] && ready[head];

    // Entries between head and head + count are in flight
    always_comb begin
        for (int i = 0; i < ROB_DEPTH; i++) begin
            live[i] = {1'b0, ROB_PTR_W'(ROB_PTR_W'(i) - head)} < count;
        end
    end

    // Results on a bus this cycle are forwarded
    always_comb begin
        lookup_ready_1 = ready[idx_1];
        lookup_data_1  = value[idx_1];
        lookup_ready_2 = ready[idx_2];
        lookup_data_2  = value[idx_2];
        if (cdb_a_valid && cdb_a_tag == lookup_tag_1) begin
            lookup_ready_1 = 1'b1;
            lookup_data_1  = cdb_a_data;
        end else if (cdb_b_valid && cdb_b_tag == lookup_tag_1) begin
            lookup_ready_1 = 1'b1;
            lookup_data_1  = cdb_b_data;
        end
        if (cdb_a_valid && cdb_a_tag == lookup_tag_2) begin
            lookup_ready_2 = 1'b1;
            lookup_data_2  = cdb_a_data;
        end else if (cdb_b_valid && cdb_b_tag == lookup_tag_2) begin
            lookup_ready_2 = 1'b1;
            lookup_data_2  = cdb_b_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            ready        <= '0;
            commit_valid <= 1'b0;
        end else begin
            head         <= head + ROB_PTR_W'(head_done);
            tail         <= tail + ROB_PTR_W'(alloc);
            count        <= count + ROB_CNT_W'(alloc) - ROB_CNT_W'(head_done);
            commit_valid <= head_done;
            if (alloc) ready[tail] <= 1'b0;
            if (cdb_a_valid) ready[idx_a] <= 1'b1;
            if (cdb_b_valid) ready[idx_b] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) rd_q[tail] <= alloc_rd;
        if (cdb_a_valid) value[idx_a] <= cdb_a_data;
        if (cdb_b_valid) value[idx_b] <= cdb_b_data;
        commit_rd   <= rd_q[head];
        commit_tag  <= tag_t'(head) + 1'b1;
        commit_data <= value[head];
    end

    a_no_alloc_full: assert property (@(posedge clk) disable iff (rst)
        alloc |-> !rob_full);

    // Each result arrives once, for a live entry
    a_bus_a_live: assert property (@(posedge clk) disable iff (rst)
        cdb_a_valid |-> cdb_a_tag != '0 && live[idx_a] && !ready[idx_a]);
    a_bus_b_live: assert property (@(posedge clk) disable iff (rst)
        cdb_b_valid |-> cdb_b_tag != '0 && live[idx_b] && !ready[idx_b]);

endmodule

//--- logic/reservation_station.sv
`timescale 1ns/1ps

module reservation_station
    import ooo_pkg::*;
#(
    parameter type op_t = alu_op_e
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            insert,
    input  op_t             insert_op,
    input  tag_t            insert_tag,
    input  tag_t            src1_tag,
    input  logic [XLEN-1:0] src1_val,
    input  tag_t            src2_tag,
    input  logic [XLEN-1:0] src2_val,
    input  logic            cdb_a_valid,
    input  tag_t            cdb_a_tag,
    input  logic [XLEN-1:0] cdb_a_data,
    input  logic            cdb_b_valid,
    input  tag_t            cdb_b_tag,
    input  logic [XLEN-1:0] cdb_b_data,
    output logic            full,
    output logic            dispatch,
    output op_t             dispatch_op,
    output tag_t            dispatch_tag,
    output logic [XLEN-1:0] dispatch_a,
    output logic [XLEN-1:0] dispatch_b
);

    logic [RS_DEPTH-1:0] valid;
    logic [RS_DEPTH-1:0] rdy;
    op_t                 op_q  [RS_DEPTH];
    tag_t                dst_q [RS_DEPTH];
    tag_t                t1_q  [RS_DEPTH];
    tag_t                t2_q  [RS_DEPTH];
    logic [XLEN-1:0]     v1_q  [RS_DEPTH];
    logic [XLEN-1:0]     v2_q  [RS_DEPTH];
    // Number of older entries still held
    logic [RS_IDX_W-1:0] age   [RS_DEPTH];
    logic [RS_IDX_W-1:0] sel;
    logic [RS_IDX_W-1:0] free_idx;
    logic [RS_IDX_W-1:0] n_stay;

    function automatic logic [TAG_W+XLEN-1:0] snoop(input tag_t t, input logic [XLEN-1:0] v);
        if (t != '0 && cdb_a_valid && cdb_a_tag == t) return {{TAG_W{1'b0}}, cdb_a_data};
        if (t != '0 && cdb_b_valid && cdb_b_tag == t) return {{TAG_W{1'b0}}, cdb_b_data};
        return {t, v};
    endfunction

    always_comb begin
        dispatch = 1'b0;
        sel      = '0;
        free_idx = '0;
        n_stay   = '0;
        // Oldest entry with both operands wins
        for (int i = 0; i < RS_DEPTH; i++) begin
            rdy[i] = valid[i] && t1_q[i] == '0 && t2_q[i] == '0;
            if (rdy[i] && (!dispatch || age[i] < age[sel])) begin
                dispatch = 1'b1;
                sel      = RS_IDX_W'(i);
            end
        end
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (!valid[i]) free_idx = RS_IDX_W'(i);
        end
        for (int i = 0; i < RS_DEPTH; i++) begin
            n_stay = n_stay + RS_IDX_W'(valid[i] && !(dispatch && sel == RS_IDX_W'(i)));
        end
    end

    assign full         = &valid;
    assign dispatch_op  = op_q[sel];
    assign dispatch_tag = dst_q[sel];
    assign dispatch_a   = v1_q[sel];
    assign dispatch_b   = v2_q[sel];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= '0;
            for (int i = 0; i < RS_DEPTH; i++) begin
                age[i] <= '0;
            end
        end else begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (dispatch && age[i] > age[sel]) age[i] <= age[i] - 1'b1;
            end
            if (dispatch) valid[sel] <= 1'b0;
            if (insert) begin
                valid[free_idx] <= 1'b1;
                age[free_idx]   <= n_stay;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            {t1_q[i], v1_q[i]} <= snoop(t1_q[i], v1_q[i]);
            {t2_q[i], v2_q[i]} <= snoop(t2_q[i], v2_q[i]);
        end
        if (insert) begin
            op_q[free_idx]  <= insert_op;
            dst_q[free_idx] <= insert_tag;
            {t1_q[free_idx], v1_q[free_idx]} <= snoop(src1_tag, src1_val);
            {t2_q[free_idx], v2_q[free_idx]} <= snoop(src2_tag, src2_val);
        end
    end

    a_no_insert_full: assert property (@(posedge clk) disable iff (rst)
        insert |-> !full);

endmodule

//--- logic/alu_unit.sv
`timescale 1ns/1ps

module alu_unit
    import ooo_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            dispatch,
    input  alu_op_e         op,
    input  tag_t            tag,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic            cdb_a_valid,
    output tag_t            cdb_a_tag,
    output logic [XLEN-1:0] cdb_a_data
);

    logic [XLEN-1:0] result;

    // Immediate forms arrive with the immediate already in b
    always_comb begin
        case (op)
            ALU_ADD, ALU_ADDI: result = a + b;
            ALU_SUB:           result = a - b;
            ALU_AND, ALU_ANDI: result = a & b;
            ALU_OR, ALU_ORI:   result = a | b;
            ALU_XOR:           result = a ^ b;
            ALU_SLT:           result = XLEN'($signed(a) < $signed(b));
            ALU_SLL:           result = a << b[4:0];
            ALU_SRL:           result = a >> b[4:0];
            default:           result = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cdb_a_valid <= 1'b0;
        end else begin
            cdb_a_valid <= dispatch;
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch) begin
            cdb_a_tag  <= tag;
            cdb_a_data <= result;
        end
    end

endmodule

//--- logic/mul_unit.sv
`timescale 1ns/1ps

module mul_unit
    import ooo_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            dispatch,
    input  mul_op_e         op,
    input  tag_t            tag,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic            cdb_b_valid,
    output tag_t            cdb_b_tag,
    output logic [XLEN-1:0] cdb_b_data
);

    logic [MUL_STAGES-1:0]    vld;
    tag_t                     tag_q  [MUL_STAGES-1];
    mul_op_e                  op_q   [MUL_STAGES-1];
    logic signed [2*XLEN-1:0] prod_q [MUL_STAGES-1];

    assign cdb_b_valid = vld[MUL_STAGES-1];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vld <= '0;
        end else begin
            vld <= {vld[MUL_STAGES-2:0], dispatch};
        end
    end

    always_ff @(posedge clk) begin
        tag_q[0]  <= tag;
        op_q[0]   <= op;
        prod_q[0] <= $signed(a) * $signed(b);
        for (int s = 1; s < MUL_STAGES - 1; s++) begin
            tag_q[s]  <= tag_q[s-1];
            op_q[s]   <= op_q[s-1];
            prod_q[s] <= prod_q[s-1];
        end
        // Half select in the last stage
        cdb_b_tag  <= tag_q[MUL_STAGES-2];
        cdb_b_data <= (op_q[MUL_STAGES-2] == MUL_HI) ? prod_q[MUL_STAGES-2][2*XLEN-1:XLEN]
                                                     : prod_q[MUL_STAGES-2][XLEN-1:0];
    end

endmodule

//--- logic/ooo_core.sv
`timescale 1ns/1ps

module ooo_core
    import ooo_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             issue_valid,
    input  op_e              issue_op,
    input  logic [REG_W-1:0] issue_rd,
    input  logic [REG_W-1:0] issue_rs,
    input  logic [REG_W-1:0] issue_rt,
    input  logic [15:0]      issue_imm,
    output logic             issue_ready,
    output logic             commit_valid,
    output logic [REG_W-1:0] commit_rd,
    output logic [XLEN-1:0]  commit_data
);

    logic            rob_full;
    logic            alu_rs_full;
    logic            mul_rs_full;
    logic            alloc;
    logic            rename_en;
    logic            alu_insert;
    logic            mul_insert;
    alu_op_e         alu_op;
    mul_op_e         mul_op;
    tag_t            alloc_tag;
    tag_t            commit_tag;
    tag_t            rs_tag;
    tag_t            rt_tag;
    tag_t            src1_tag;
    tag_t            src2_tag;
    logic [XLEN-1:0] rs_value;
    logic [XLEN-1:0] rt_value;
    logic [XLEN-1:0] src1_val;
    logic [XLEN-1:0] src2_val;
    logic            lookup_ready_1;
    logic            lookup_ready_2;
    logic [XLEN-1:0] lookup_data_1;
    logic [XLEN-1:0] lookup_data_2;

    // Station to unit
    logic            alu_dispatch;
    alu_op_e         alu_d_op;
    tag_t            alu_d_tag;
    logic [XLEN-1:0] alu_d_a;
    logic [XLEN-1:0] alu_d_b;
    logic            mul_dispatch;
    mul_op_e         mul_d_op;
    tag_t            mul_d_tag;
    logic [XLEN-1:0] mul_d_a;
    logic [XLEN-1:0] mul_d_b;

    // Result buses
    logic            cdb_a_valid;
    tag_t            cdb_a_tag;
    logic [XLEN-1:0] cdb_a_data;
    logic            cdb_b_valid;
    tag_t            cdb_b_tag;
    logic [XLEN-1:0] cdb_b_data;

    issue_ctrl issue_ctrl_inst (.*);

    rename_regfile rename_regfile_inst (
        .rd_rs      (issue_rs),
        .rd_rt      (issue_rt),
        .rename_rd  (issue_rd),
        .rename_tag (alloc_tag),
        .commit_en  (commit_valid),
        .*
    );

    reorder_buffer reorder_buffer_inst (
        .alloc_rd     (issue_rd),
        .lookup_tag_1 (rs_tag),
        .lookup_tag_2 (rt_tag),
        .*
    );

    reservation_station #(.op_t(alu_op_e)) alu_rs (
        .insert       (alu_insert),
        .insert_op    (alu_op),
        .insert_tag   (alloc_tag),
        .full         (alu_rs_full),
        .dispatch     (alu_dispatch),
        .dispatch_op  (alu_d_op),
        .dispatch_tag (alu_d_tag),
        .dispatch_a   (alu_d_a),
        .dispatch_b   (alu_d_b),
        .*
    );

    reservation_station #(.op_t(mul_op_e)) mul_rs (
        .insert       (mul_insert),
        .insert_op    (mul_op),
        .insert_tag   (alloc_tag),
        .full         (mul_rs_full),
        .dispatch     (mul_dispatch),
        .dispatch_op  (mul_d_op),
        .dispatch_tag (mul_d_tag),
        .dispatch_a   (mul_d_a),
        .dispatch_b   (mul_d_b),
        .*
    );

    alu_unit alu_unit_inst (
        .dispatch (alu_dispatch),
        .op       (alu_d_op),
        .tag      (alu_d_tag),
        .a        (alu_d_a),
        .b        (alu_d_b),
        .*
    );

    mul_unit mul_unit_inst (
        .dispatch (mul_dispatch),
        .op       (mul_d_op),
        .tag      (mul_d_tag),
        .a        (mul_d_a),
        .b        (mul_d_b),
        .*
    );

endmodule

//--- tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst
);

    initial clk = 1'b0;

    // 10 ns period
    always #5 clk = ~clk;

    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

//--- tests/ooo_core_tb.sv
`timescale 1ns/1ps

module ooo_core_tb
    import ooo_pkg::*;
;

    localparam int N_BASIC   = 18;
    localparam int N_CHAIN   = 10;
    localparam int N_BURST   = 33;
    localparam int N_ZERO    = 6;
    localparam int N_RANDOM  = 400;
    localparam int N_INSTR   = N_BASIC + N_CHAIN + N_BURST + N_ZERO + N_RANDOM;
    localparam int TIMEOUT_CYCLES = 20 * N_INSTR + 200;
    localparam int DRAIN_CYCLES   = 20 * ROB_DEPTH;

    logic             clk;
    logic             rst;
    logic             issue_valid;
    op_e              issue_op;
    logic [REG_W-1:0] issue_rd;
    logic [REG_W-1:0] issue_rs;
    logic [REG_W-1:0] issue_rt;
    logic [15:0]      issue_imm;
    logic             issue_ready;
    logic             commit_valid;
    logic [REG_W-1:0] commit_rd;
    logic [XLEN-1:0]  commit_data;

    logic [XLEN-1:0]  model_regs [NUM_REGS];
    logic [REG_W-1:0] exp_rd_q [$];
    logic [XLEN-1:0]  exp_data_q [$];
    logic [REG_W-1:0] exp_rd;
    logic [XLEN-1:0]  exp_data;
    logic [31:0]      lfsr = 32'h0f5a8703;
    logic             saw_stall;
    int               n_accepted;
    int               n_commits;
    int               cycle_count;
    int               drain_cycles;

    tb_clock tb_clock_inst (.clk(clk), .rst(rst));

    ooo_core ooo_core_inst (.*);

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // One LFSR step per bit
    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[14:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [XLEN-1:0] expected_result(
        input op_e             op,
        input logic [XLEN-1:0] a,
        input logic [XLEN-1:0] b,
        input logic [15:0]     imm
    );
        logic [63:0] prod;
        // Sign-extended operands give the signed 64-bit product
        prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_SLL:  return a << imm[4:0];
            OP_SRL:  return a >> imm[4:0];
            OP_ADDI: return a + {{16{imm[15]}}, imm};
            OP_ANDI: return a & {16'h0000, imm};
            OP_ORI:  return a | {16'h0000, imm};
            OP_MUL:  return prod[31:0];
            OP_MULH: return prod[63:32];
            default: return '0;
        endcase
    endfunction

    task automatic check_idle_outputs();
        assert (commit_valid === 1'b0) else stop_on_error($sformatf(
            "** Error at %0t: commit_valid = %b, expected 0", $time, commit_valid));
        assert (issue_ready === 1'b1) else stop_on_error($sformatf(
            "** Error at %0t: issue_ready = %b, expected 1", $time, issue_ready));
    endtask

    task automatic idle_cycle();
        issue_valid <= 1'b0;
        @(posedge clk);
    endtask

    // Called on a rising edge, returns on the edge that accepts
    task automatic issue(
        input op_e              op,
        input logic [REG_W-1:0] rd,
        input logic [REG_W-1:0] rs,
        input logic [REG_W-1:0] rt,
        input logic [15:0]      imm
    );
        logic            ready_seen;
        logic [XLEN-1:0] result;
        issue_valid <= 1'b1;
        issue_op    <= op;
        issue_rd    <= rd;
        issue_rs    <= rs;
        issue_rt    <= rt;
        issue_imm   <= imm;
        do begin
            @(negedge clk);
            ready_seen = issue_ready;
            if (!ready_seen) saw_stall = 1'b1;
            @(posedge clk);
        end while (!ready_seen);
        result = expected_result(op, model_regs[rs], model_regs[rt], imm);
        exp_rd_q.push_back(rd);
        exp_data_q.push_back(result);
        if (rd != '0) model_regs[rd] = result;
        n_accepted++;
    endtask

    task automatic basic_ops();
        issue(OP_ADDI, 1, 0, 0, 16'h1234);
        issue(OP_ADDI, 2, 0, 0, 16'hfffb);
        issue(OP_ADDI, 3, 0, 0, 16'h7fff);
        issue(OP_ADDI, 4, 0, 0, 16'h8000);
        issue(OP_ADDI, 5, 0, 0, 16'h0003);
        issue(OP_ADDI, 6, 0, 0, 16'h00f0);
        issue(OP_ADD, 8, 1, 2, 16'h0);
        issue(OP_SUB, 9, 2, 1, 16'h0);
        issue(OP_AND, 10, 1, 6, 16'h0);
        issue(OP_OR, 11, 1, 6, 16'h0);
        issue(OP_XOR, 12, 3, 4, 16'h0);
        issue(OP_SLT, 13, 2, 5, 16'h0);
        issue(OP_SLT, 14, 5, 2, 16'h0);
        issue(OP_SLL, 15, 1, 0, 16'h0004);
        issue(OP_SRL, 16, 4, 0, 16'h0008);
        issue(OP_ADDI, 17, 2, 0, 16'h8001);
        issue(OP_ANDI, 18, 4, 0, 16'hff0f);
        issue(OP_ORI, 19, 2, 0, 16'h0a0a);
    endtask

    task automatic dependency_chains();
        issue(OP_MUL, 20, 1, 2, 16'h0);
        issue(OP_ADD, 21, 20, 5, 16'h0);
        issue(OP_MULH, 22, 21, 4, 16'h0);
        issue(OP_MUL, 23, 22, 22, 16'h0);
        issue(OP_SUB, 24, 23, 20, 16'h0);
        issue(OP_MULH, 25, 4, 4, 16'h0);
        issue(OP_MULH, 26, 2, 3, 16'h0);
        issue(OP_XOR, 20, 26, 24, 16'h0);
        issue(OP_MUL, 21, 20, 20, 16'h0);
        issue(OP_ADDI, 27, 21, 0, 16'h0001);
    endtask

    task automatic multiply_burst();
        saw_stall = 1'b0;
        issue(OP_ADDI, 7, 0, 0, 16'h0003);
        // Back-to-back dependent multiplies fill the station
        for (int i = 0; i < 8; i++) begin
            issue(OP_MUL, 7, 7, 5, 16'h0);
        end
        // ALU work queued behind slow multiplies fills the ROB
        for (int i = 0; i < 4; i++) begin
            issue(OP_MUL, 7, 7, 5, 16'h0);
            for (int j = 0; j < 5; j++) begin
                issue(OP_ADDI, 29, 29, 0, 16'(i * 5 + j + 1));
            end
        end
        assert (saw_stall) else
            stop_on_error("issue_ready never went low during the multiply burst");
    endtask

    task automatic zero_register();
        issue(OP_ADDI, 0, 1, 0, 16'h0055);
        issue(OP_MUL, 0, 2, 2, 16'h0);
        issue(OP_ADD, 30, 0, 1, 16'h0);
        issue(OP_OR, 31, 0, 0, 16'h0);
        issue(OP_MULH, 0, 3, 3, 16'h0);
        issue(OP_SLL, 30, 0, 0, 16'h0003);
    endtask

    task automatic random_stream();
        op_e              op;
        logic [REG_W-1:0] rd;
        logic [REG_W-1:0] rs;
        logic [REG_W-1:0] rt;
        logic [15:0]      imm;
        for (int i = 0; i < N_RANDOM; i++) begin
            if (take_bits(2) == 16'd3) idle_cycle();
            op  = op_e'(4'(take_bits(4) % 16'd13));
            rd  = REG_W'(take_bits(3));
            rs  = REG_W'(take_bits(3));
            rt  = REG_W'(take_bits(3));
            imm = take_bits(16);
            issue(op, rd, rs, rt, imm);
        end
    endtask

    // Commit checker samples away from the rising edge
    always @(negedge clk) begin
        if (!rst && commit_valid) begin
            assert (exp_rd_q.size() > 0) else
                stop_on_error("A commit was reported with no instruction outstanding");
            exp_rd   = exp_rd_q.pop_front();
            exp_data = exp_data_q.pop_front();
            assert (commit_rd === exp_rd) else stop_on_error($sformatf(
                "** Error at %0t: commit_rd = %0d, expected %0d", $time, commit_rd, exp_rd));
            assert (commit_data === exp_data) else stop_on_error($sformatf(
                "** Error at %0t: commit_data = %h, expected %h",
                $time, commit_data, exp_data));
            n_commits++;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        assert (cycle_count < TIMEOUT_CYCLES) else
            stop_on_error("Timeout: the core stopped accepting or committing instructions");
    end

    initial begin
        issue_valid  = 1'b0;
        issue_op     = OP_ADD;
        issue_rd     = '0;
        issue_rs     = '0;
        issue_rt     = '0;
        issue_imm    = '0;
        saw_stall    = 1'b0;
        n_accepted   = 0;
        n_commits    = 0;
        cycle_count  = 0;
        drain_cycles = 0;
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
        end

        do begin
            @(negedge clk);
            check_idle_outputs();
        end while (rst);
        @(negedge clk);
        check_idle_outputs();

        @(posedge clk);
        basic_ops();
        dependency_chains();
        multiply_burst();
        zero_register();
        random_stream();
        idle_cycle();

        while (n_commits != n_accepted && drain_cycles < DRAIN_CYCLES) begin
            @(posedge clk);
            drain_cycles++;
        end
        // A stray commit after draining shows up in the checker
        repeat (10) @(posedge clk);

        if (exp_rd_q.size() == 0 && n_commits == n_accepted) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            stop_on_error("Commits did not match the accepted instructions at the end");
        end
    end

endmodule

//--- all.f
logic/ooo_pkg.sv
logic/issue_ctrl.sv
logic/rename_regfile.sv
logic/reorder_buffer.sv
logic/reservation_station.sv
logic/alu_unit.sv
logic/mul_unit.sv
logic/ooo_core.sv
tests/tb_clock.sv
tests/ooo_core_tb.sv
